//--- decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// decode field widths
`define REG_ID_W 6
`define IMM_W 33
`define UCMD_W 8

// register block bus
`define WB_ADDR_W 4
`define CSR_CTRL 4'h0
`define CSR_INVCOUNT 4'h4
`define CSR_INVWORD 4'h8

// special register numbers
`define GR_ZZR 6'h3F
`define GR_IMM 6'h3E
`define GR_DLR 6'h20
`define GR_PC 6'h22
`define GR_GBR 6'h26
`define GR_TBR 6'h27

`endif

//--- logic/decodePkg.sv
`include "decode_config.svh"

package decodePkg;

	// register view, minor nibble in the upper half
	typedef struct packed {
		logic [3:0] minor;
		logic       exQ;
		logic       exN;
		logic       exM;
		logic       exI;
		logic [3:0] o;
		logic [3:0] low;
		logic [3:0] prefix;
		logic [3:0] group;
		logic [3:0] n;
		logic [3:0] m;
	} regView_t;

	typedef struct packed {
		logic [15:0] immHi;
		logic [7:0]  groupByte;
		logic [7:0]  lowByte;
	} immView_t;

	typedef union packed {
		regView_t r;
		immView_t i;
	} instrWord_t;

	typedef enum logic [5:0] {
		NM_INVOP = 6'h00, NM_MOV_RM = 6'h01, NM_MOV_MR = 6'h02, NM_LEA_MR = 6'h03,
		NM_ALU3 = 6'h04, NM_ALUCMP = 6'h05, NM_MUL3 = 6'h06, NM_MOV_RC = 6'h07,
		NM_MOV_CR = 6'h08, NM_CONV_RR = 6'h09, NM_BRA = 6'h0A, NM_BSR = 6'h0B,
		NM_SHAD3 = 6'h0C, NM_SHLD3 = 6'h0D, NM_SHADQ3 = 6'h0E, NM_SHLDQ3 = 6'h0F,
		NM_MOV_IR = 6'h10
	} nmid_t;

	typedef enum logic [4:0] {
		FM_INV = 5'h00, FM_REG = 5'h01, FM_REGREG = 5'h02, FM_REGIMMREG = 5'h03,
		FM_REGSTREGDISP = 5'h04, FM_LDREGDISPREG = 5'h05, FM_REGSTDRREG = 5'h06,
		FM_LDDRREGREG = 5'h07, FM_IMM8REG = 5'h08, FM_PCDISP8 = 5'h09,
		FM_IMM12Z = 5'h0A, FM_IMM12N = 5'h0B
	} fmid_t;

	typedef enum logic [3:0] {
		ITY_SB = 4'h0, ITY_SW = 4'h1, ITY_SQ = 4'h3,
		ITY_UB = 4'h4, ITY_UW = 4'h5, ITY_UQ = 4'h7,
		ITY_NB = 4'h8, ITY_NW = 4'h9, ITY_NQ = 4'hB
	} ity_t;

	// bit 2 marks the unsigned sizes
	typedef enum logic [2:0] {
		BTY_SB = 3'd0, BTY_SW = 3'd1, BTY_SL = 3'd2, BTY_SQ = 3'd3,
		BTY_UB = 3'd4, BTY_UW = 3'd5, BTY_UL = 3'd6
	} bty_t;

	typedef enum logic [1:0] {
		CC_AL = 2'd0, CC_CT = 2'd1, CC_CF = 2'd2
	} ccty_t;

	typedef logic [`REG_ID_W-1:0] regId_t;
	typedef logic [`IMM_W-1:0] imm_t;

	localparam logic [5:0] UCIX_ADD = 6'h00;
	localparam logic [5:0] UCIX_SUB = 6'h01;
	localparam logic [5:0] UCIX_ADC = 6'h02;
	localparam logic [5:0] UCIX_SBB = 6'h03;
	localparam logic [5:0] UCIX_TST = 6'h04;
	localparam logic [5:0] UCIX_AND = 6'h05;
	localparam logic [5:0] UCIX_OR = 6'h06;
	localparam logic [5:0] UCIX_XOR = 6'h07;
	localparam logic [5:0] UCIX_CMPEQ = 6'h0C;
	localparam logic [5:0] UCIX_CMPHI = 6'h0D;
	localparam logic [5:0] UCIX_CMPGT = 6'h0E;
	localparam logic [5:0] UCIX_ADDSL = 6'h10;
	localparam logic [5:0] UCIX_ADDUL = 6'h11;
	localparam logic [5:0] UCIX_SUBSL = 6'h12;
	localparam logic [5:0] UCIX_SUBUL = 6'h13;
	localparam logic [5:0] UCIX_MUL3S = 6'h00;
	localparam logic [5:0] UCIX_MULS = 6'h01;
	localparam logic [5:0] UCIX_MULU = 6'h02;
	localparam logic [5:0] UCIX_LDIX = 6'h00;
	localparam logic [5:0] UCIX_LDISH16 = 6'h01;

endpackage

//--- logic/opClassifier.sv
`timescale 1ns/1ps

module opClassifier (
	input  decodePkg::instrWord_t instrWord,
	input  logic                  addslEnable,
	output decodePkg::nmid_t      nmid,
	output decodePkg::fmid_t      fmid,
	output decodePkg::ity_t       ity,
	output decodePkg::bty_t       bty,
	output decodePkg::ccty_t      ccty,
	output logic [5:0]            ucmdIx,
	output logic                  illegal
);
	import decodePkg::*;

	logic exQ;
	logic prefixOk;

	// Q selects the unsigned size, quad has no unsigned form so it becomes UL
	function automatic bty_t loadSize(input logic [1:0] size, input logic q);
		bty_t sz;
		if (!q)
			sz = bty_t'({1'b0, size});
		else if (size == 2'd3)
			sz = BTY_UL;
		else
			sz = bty_t'({1'b1, size});
		return sz;
	endfunction

	assign exQ = instrWord.r.exQ;
	assign prefixOk = (instrWord.r.prefix[3:1] == 3'b111);

	always_comb begin
		nmid = NM_INVOP;
		fmid = FM_INV;
		ity = ITY_SB;
		bty = BTY_SB;
		ccty = CC_AL;
		ucmdIx = 6'h00;

		casez (instrWord.r.group)
			4'b0z00: begin
				casez (instrWord.i.immHi)
					16'h0zz4, 16'h0zz5, 16'h0zz6, 16'h0zz7: begin
						nmid = exQ ? NM_LEA_MR : NM_MOV_RM;
						fmid = exQ ? FM_LDDRREGREG : FM_REGSTDRREG;
						bty = bty_t'({1'b0, instrWord.r.low[1:0]});
						ity = ITY_UB;
					end
					16'h0zzC, 16'h0zzD, 16'h0zzE, 16'h0zzF: begin
						nmid = NM_MOV_MR;
						fmid = FM_LDDRREGREG;
						bty = loadSize(instrWord.r.low[1:0], exQ);
						ity = ITY_UB;
					end
					16'h1zz0, 16'h1zz1, 16'h1zz5, 16'h1zz6, 16'h1zz7: begin
						// low nibble equals the ALU sub-op here
						nmid = NM_ALU3;
						fmid = FM_REGREG;
						ucmdIx = {2'b00, instrWord.r.low};
					end
					16'h1zz2: begin
						nmid = NM_MUL3;
						fmid = FM_REGREG;
						ucmdIx = UCIX_MUL3S;
					end
					16'h1zz9: begin
						fmid = FM_REGREG;
						case (instrWord.r.o)
							4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'h6, 4'h7: begin
								nmid = NM_ALU3;
								ity = ITY_NB;
								ucmdIx = {2'b00, instrWord.r.o};
							end
							4'h4: begin
								nmid = NM_ALUCMP;
								ucmdIx = UCIX_TST;
							end
							4'h8: nmid = NM_CONV_RR;
							4'h9: begin
								nmid = NM_MUL3;
								ucmdIx = UCIX_MULS;
							end
							4'hA: begin
								nmid = NM_MOV_RC;
								ity = ITY_UB;
							end
							4'hB: begin
								nmid = NM_MOV_CR;
								ity = ITY_UW;
							end
							4'hC: begin
								nmid = NM_ALUCMP;
								ucmdIx = UCIX_CMPEQ;
							end
							4'hD: begin
								nmid = NM_ALUCMP;
								ucmdIx = UCIX_CMPHI;
							end
							4'hE: begin
								nmid = NM_ALUCMP;
								ucmdIx = UCIX_CMPGT;
							end
							default: begin
								nmid = NM_MUL3;
								ucmdIx = UCIX_MULU;
							end
						endcase
					end
					16'h5zzC, 16'h5zzD: begin
						if (addslEnable) begin
							nmid = NM_ALU3;
							fmid = FM_REGREG;
							if (instrWord.r.low[0])
								ucmdIx = exQ ? UCIX_SUBUL : UCIX_SUBSL;
							else
								ucmdIx = exQ ? UCIX_ADDUL : UCIX_ADDSL;
						end
					end
					16'b11zz_zzzz_zzzz_zzzz: begin
						// Czzz..Fzzz displacement branches
						nmid = (instrWord.r.minor == 4'hD) ? NM_BSR : NM_BRA;
						fmid = FM_PCDISP8;
						bty = BTY_SW;
						ity = ITY_SW;
						if (instrWord.r.minor == 4'hE)
							ccty = CC_CT;
						else if (instrWord.r.minor == 4'hF)
							ccty = CC_CF;
					end
					default: ;
				endcase
			end
			4'b0z01: begin
				case (instrWord.r.minor)
					4'h0, 4'h1, 4'h2, 4'h3: begin
						nmid = exQ ? NM_LEA_MR : NM_MOV_RM;
						fmid = exQ ? FM_LDREGDISPREG : FM_REGSTREGDISP;
						bty = bty_t'({1'b0, instrWord.r.minor[1:0]});
						ity = ITY_SW;
					end
					4'h8, 4'h9, 4'hA, 4'hB: begin
						nmid = NM_MOV_MR;
						fmid = FM_LDREGDISPREG;
						bty = loadSize(instrWord.r.minor[1:0], exQ);
						ity = ITY_SW;
					end
					default: ;
				endcase
			end
			4'b0z10: begin
				fmid = FM_REGIMMREG;
				ity = ITY_UW;
				case (instrWord.r.minor)
					4'h0: nmid = NM_ALU3;
					4'h1: begin
						nmid = NM_ALU3;
						ity = ITY_NW;
					end
					4'h2: nmid = NM_MUL3;
					4'h3, 4'h4: begin
						if (addslEnable) begin
							nmid = NM_ALU3;
							ity = instrWord.r.minor[0] ? ITY_UW : ITY_NW;
							ucmdIx = exQ ? UCIX_ADDUL : UCIX_ADDSL;
						end
					end
					4'h5, 4'h6, 4'h7: begin
						nmid = NM_ALU3;
						ucmdIx = {2'b00, instrWord.r.minor};
					end
					4'h8: nmid = exQ ? NM_SHADQ3 : NM_SHAD3;
					4'h9: nmid = exQ ? NM_SHLDQ3 : NM_SHLD3;
					default: ;
				endcase
			end
			4'h8: begin
				fmid = FM_IMM8REG;
				case (instrWord.i.lowByte[7:5])
					3'd0: begin
						nmid = NM_MOV_IR;
						ity = ITY_UW;
						ucmdIx = UCIX_LDIX;
					end
					3'd1: begin
						nmid = NM_MOV_IR;
						ity = ITY_NW;
						ucmdIx = UCIX_LDIX;
					end
					3'd2: begin
						nmid = NM_ALU3;
						ity = ITY_SW;
						ucmdIx = UCIX_ADD;
					end
					3'd3: begin
						nmid = NM_MOV_IR;
						ity = ITY_UW;
						ucmdIx = UCIX_LDISH16;
					end
					default: ;
				endcase
			end
			4'hA, 4'hB: begin
				nmid = NM_MOV_IR;
				fmid = instrWord.r.group[0] ? FM_IMM12N : FM_IMM12Z;
				ucmdIx = UCIX_LDIX;
			end
			default: ;
		endcase

		illegal = !prefixOk || (nmid == NM_INVOP);
		if (illegal) begin
			nmid = NM_INVOP;
			fmid = FM_INV;
			ity = ITY_SB;
			bty = BTY_SB;
			ccty = CC_AL;
			ucmdIx = 6'h00;
		end
	end

endmodule

//--- logic/operandFormer.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module operandFormer (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  instrValid,
	input  decodePkg::instrWord_t instrWord,
	input  decodePkg::nmid_t      nmid,
	input  decodePkg::fmid_t      fmid,
	input  decodePkg::ity_t       ity,
	input  decodePkg::bty_t       bty,
	input  decodePkg::ccty_t      ccty,
	input  logic [5:0]            ucmdIx,
	output logic                  opValid,
	output decodePkg::regId_t     regN,
	output decodePkg::regId_t     regM,
	output decodePkg::regId_t     regO,
	output decodePkg::imm_t       imm,
	output logic [`UCMD_W-1:0]    uCmd,
	output logic [`UCMD_W-1:0]    uIxt
);
	import decodePkg::*;

	// special bit for R0, R1 and R15 style nibbles
	function automatic regId_t dflReg(input logic ext, input logic [3:0] nib);
		return {(nib[3:1] == 3'b000) || (nib == 4'hF), ext, nib};
	endfunction

	logic [15:0] hiHalf;
	logic [7:0] loByte;
	regId_t regNDfl;
	regId_t regMDfl;
	regId_t regODfl;
	regId_t regODf2;
	regId_t baseReg;
	regId_t dataReg;
	regId_t pcGbr;
	logic stForm;
	logic baseRz;
	logic baseR1;
	logic idxR1;
	imm_t imm17s;
	imm_t imm17u;
	imm_t imm17n;
	imm_t imm10s;
	imm_t imm10u;
	imm_t imm10n;
	imm_t disp20s;
	logic [`UCMD_W-1:0] sizeFull;
	logic [`UCMD_W-1:0] sizeRed;
	regId_t nextN;
	regId_t nextM;
	regId_t nextO;
	imm_t nextImm;
	logic [`UCMD_W-1:0] nextUIxt;

	assign hiHalf = {instrWord.r.minor, instrWord.r.exQ, instrWord.r.exN, instrWord.r.exM,
		instrWord.r.exI, instrWord.r.o, instrWord.r.low};
	assign loByte = {instrWord.r.n, instrWord.r.m};

	assign regNDfl = dflReg(instrWord.r.exN, instrWord.r.n);
	assign regMDfl = dflReg(instrWord.r.exM, instrWord.r.m);
	assign regODfl = dflReg(instrWord.r.exI, instrWord.r.o);
	assign regODf2 = dflReg(instrWord.r.n[0], instrWord.r.m);

	assign imm17u = {24'h0, hiHalf[8:0]};
	assign imm17n = {{24{1'b1}}, hiHalf[8:0]};
	assign imm17s = {{24{hiHalf[8]}}, hiHalf[8:0]};
	assign imm10u = {23'h0, hiHalf[9:0]};
	assign imm10n = {{23{1'b1}}, hiHalf[9:0]};
	assign imm10s = {{23{hiHalf[9]}}, hiHalf[9:0]};
	assign disp20s = {{13{loByte[7]}}, loByte, hiHalf[11:0]};

	// store forms swap the data and base roles
	assign stForm = (fmid == FM_REGSTREGDISP) || (fmid == FM_REGSTDRREG);
	assign baseReg = stForm ? regNDfl : regMDfl;
	assign dataReg = stForm ? regMDfl : regNDfl;
	assign baseRz = (baseReg[4:1] == 4'b0000);
	assign baseR1 = baseRz && baseReg[0];
	assign idxR1 = (regODfl[4:1] == 4'b0000) && regODfl[0];
	assign pcGbr = baseR1 ? `GR_GBR : `GR_PC;
	assign sizeFull = {ccty, bty[1:0], !stForm, bty};
	assign sizeRed = {ccty, bty[1:0], !stForm, bty[2], 2'b00};

	always_comb begin
		nextN = `GR_ZZR;
		nextM = `GR_ZZR;
		nextO = `GR_ZZR;
		nextImm = '0;
		nextUIxt = '0;
		case (fmid)
			FM_REGREG: begin
				// NB is the two-operand form Rn = Rn op Rm
				nextN = regNDfl;
				nextM = (ity == ITY_NB) ? regNDfl : regMDfl;
				nextO = (ity == ITY_NB) ? regMDfl : regODfl;
				nextImm = {28'h0, instrWord.r.n[0], instrWord.r.m};
				nextUIxt = {ccty, ucmdIx};
			end
			FM_REGIMMREG: begin
				nextN = regNDfl;
				nextM = regMDfl;
				nextO = `GR_IMM;
				nextUIxt = {ccty, ucmdIx};
				case (ity)
					ITY_UW: nextImm = imm17u;
					ITY_NW: nextImm = imm17n;
					default: nextImm = imm17s;
				endcase
			end
			FM_REGSTREGDISP, FM_LDREGDISPREG: begin
				nextN = dataReg;
				nextM = baseRz ? pcGbr : baseReg;
				nextO = `GR_IMM;
				nextImm = imm17s;
				nextUIxt = baseRz ? sizeRed : sizeFull;
			end
			FM_REGSTDRREG, FM_LDDRREGREG: begin
				nextN = dataReg;
				nextM = baseReg;
				nextO = regODfl;
				nextUIxt = sizeFull;
				if (baseRz) begin
					nextUIxt = sizeRed;
					nextM = pcGbr;
					if (idxR1) begin
						// R1 index on a PC or GBR base
						nextM = baseR1 ? `GR_TBR : `GR_DLR;
						nextO = baseR1 ? `GR_DLR : `GR_ZZR;
					end
				end
			end
			FM_IMM8REG: begin
				nextN = regODf2;
				nextM = `GR_IMM;
				nextO = regODf2;
				nextUIxt = {ccty, ucmdIx};
				case (ity)
					ITY_SW: nextImm = {{17{hiHalf[15]}}, hiHalf};
					ITY_UW: nextImm = {17'h0, hiHalf};
					ITY_NW: nextImm = {{17{1'b1}}, hiHalf};
					ITY_SQ: nextImm = imm10s;
					ITY_UQ: nextImm = imm10u;
					ITY_NQ: nextImm = imm10n;
					default: nextImm = '0;
				endcase
				if (ity inside {ITY_SQ, ITY_UQ, ITY_NQ}) begin
					nextN = regNDfl;
					nextO = regNDfl;
				end
			end
			FM_PCDISP8: begin
				nextN = `GR_DLR;
				nextM = `GR_PC;
				nextO = `GR_IMM;
				nextImm = disp20s;
				nextUIxt = sizeFull;
			end
			FM_IMM12Z, FM_IMM12N: begin
				nextN = `GR_DLR;
				nextM = `GR_IMM;
				nextImm = {(fmid == FM_IMM12N) ? 9'h1FF : 9'h000, loByte, hiHalf};
				nextUIxt = {ccty, ucmdIx};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			opValid <= 1'b0;
			regN <= '0;
			regM <= '0;
			regO <= '0;
			imm <= '0;
			uCmd <= '0;
			uIxt <= '0;
		end else begin
			opValid <= instrValid;
			if (instrValid) begin
				regN <= nextN;
				regM <= nextM;
				regO <= nextO;
				imm <= nextImm;
				uCmd <= {ccty, nmid};
				uIxt <= nextUIxt;
			end
		end
	end

endmodule

//--- logic/decodeCsr.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module decodeCsr (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  wbCyc,
	input  logic                  wbStb,
	input  logic                  wbWe,
	input  logic [`WB_ADDR_W-1:0] wbAdr,
	input  logic [31:0]           wbDatI,
	output logic [31:0]           wbDatO,
	output logic                  wbAck,
	input  logic                  instrValid,
	input  decodePkg::instrWord_t instrWord,
	input  logic                  illegal,
	output logic                  addslEnable
);
	logic        wbReq;
	logic        wbWrite;
	logic        invSeen;
	logic [15:0] invCount;
	logic [31:0] invWord;

	// new request only while ack is low
	assign wbReq = wbCyc && wbStb && !wbAck;
	assign wbWrite = wbReq && wbWe;
	assign invSeen = instrValid && illegal;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			addslEnable <= 1'b1;
			invCount <= 16'h0;
			invWord <= 32'h0;
		end else begin
			wbAck <= wbReq;
			if (wbWrite && (wbAdr == `CSR_CTRL))
				addslEnable <= wbDatI[0];
			// clear wins over a same-cycle count
			if (wbWrite && (wbAdr == `CSR_INVCOUNT))
				invCount <= 16'h0;
			else if (invSeen && (invCount != 16'hFFFF))
				invCount <= invCount + 16'h1;
			if (invSeen)
				invWord <= instrWord.r;
		end
	end

	always_comb begin
		case (wbAdr)
			`CSR_CTRL: wbDatO = {31'h0, addslEnable};
			`CSR_INVCOUNT: wbDatO = {16'h0, invCount};
			`CSR_INVWORD: wbDatO = invWord;
			default: wbDatO = 32'h0;
		endcase
	end

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module instrDecoder (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  instrValid,
	input  decodePkg::instrWord_t instrWord,
	output logic                  opValid,
	output decodePkg::regId_t     regN,
	output decodePkg::regId_t     regM,
	output decodePkg::regId_t     regO,
	output decodePkg::imm_t       imm,
	output logic [`UCMD_W-1:0]    uCmd,
	output logic [`UCMD_W-1:0]    uIxt,
	input  logic                  wbCyc,
	input  logic                  wbStb,
	input  logic                  wbWe,
	input  logic [`WB_ADDR_W-1:0] wbAdr,
	input  logic [31:0]           wbDatI,
	output logic [31:0]           wbDatO,
	output logic                  wbAck
);
	import decodePkg::*;

	nmid_t nmid;
	fmid_t fmid;
	ity_t ity;
	bty_t bty;
	ccty_t ccty;
	logic [5:0] ucmdIx;
	logic illegal;
	logic addslEnable;

	opClassifier classifier (
		.instrWord(instrWord),
		.addslEnable(addslEnable),
		.nmid(nmid),
		.fmid(fmid),
		.ity(ity),
		.bty(bty),
		.ccty(ccty),
		.ucmdIx(ucmdIx),
		.illegal(illegal)
	);

	operandFormer former (
		.clock(clock),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrWord(instrWord),
		.nmid(nmid),
		.fmid(fmid),
		.ity(ity),
		.bty(bty),
		.ccty(ccty),
		.ucmdIx(ucmdIx),
		.opValid(opValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.uCmd(uCmd),
		.uIxt(uIxt)
	);

	decodeCsr csr (
		.clock(clock),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbDatO(wbDatO),
		.wbAck(wbAck),
		.instrValid(instrValid),
		.instrWord(instrWord),
		.illegal(illegal),
		.addslEnable(addslEnable)
	);

endmodule

//--- test/decodeVectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// stimulus word with its expected registered outputs
typedef struct packed {
	logic [31:0] word;
	logic [5:0]  regN;
	logic [5:0]  regM;
	logic [5:0]  regO;
	logic [32:0] imm;
	logic [7:0]  uCmd;
	logic [7:0]  uIxt;
	logic        illegal;
} decodeVec_t;

decodeVec_t vecs[$];

task automatic addVector(input logic [31:0] word, input logic [5:0] regN,
	input logic [5:0] regM, input logic [5:0] regO, input logic [32:0] imm,
	input logic [7:0] uCmd, input logic [7:0] uIxt, input logic illegal);
	decodeVec_t v;
	v.word = word;
	v.regN = regN;
	v.regM = regM;
	v.regO = regO;
	v.imm = imm;
	v.uCmd = uCmd;
	v.uIxt = uIxt;
	v.illegal = illegal;
	vecs.push_back(v);
endtask

// columns are word, regN, regM, regO, imm, uCmd, uIxt, illegal
task automatic loadMainVectors();
	// register ALU in three and two operand forms
	addVector(32'h1040_F023, 6'h02, 6'h03, 6'h04, 33'h3, 8'h04, 8'h00, 1'b0);
	addVector(32'h1601_F00F, 6'h30, 6'h3F, 6'h20, 33'hF, 8'h04, 8'h01, 1'b0);
	addVector(32'h1079_F056, 6'h05, 6'h05, 6'h06, 33'h16, 8'h04, 8'h07, 1'b0);
	addVector(32'h10A2_F089, 6'h08, 6'h09, 6'h0A, 33'h9, 8'h06, 8'h00, 1'b0);
	addVector(32'h504C_F023, 6'h02, 6'h03, 6'h04, 33'h3, 8'h04, 8'h10, 1'b0);
	// F2 immediate ALU with zero and one extension
	addVector(32'h0123_F223, 6'h02, 6'h03, `GR_IMM, 33'h123, 8'h04, 8'h00, 1'b0);
	addVector(32'h1045_F267, 6'h06, 6'h07, `GR_IMM, 33'h1_FFFF_FE45, 8'h04, 8'h00, 1'b0);
	addVector(32'h3045_F223, 6'h02, 6'h03, `GR_IMM, 33'h45, 8'h04, 8'h10, 1'b0);
	// F8 load immediate and signed add
	addVector(32'hABCD_F805, 6'h05, `GR_IMM, 6'h05, 33'hABCD, 8'h10, 8'h00, 1'b0);
	addVector(32'h00F0_F834, 6'h14, `GR_IMM, 6'h14, 33'h1_FFFF_00F0, 8'h10, 8'h00, 1'b0);
	addVector(32'h8001_F852, 6'h12, `GR_IMM, 6'h12, 33'h1_FFFF_8001, 8'h04, 8'h00, 1'b0);
	// FA/FB 24-bit loads into DLR
	addVector(32'h1234_EA56, `GR_DLR, `GR_IMM, `GR_ZZR, 33'h56_1234, 8'h10, 8'h00, 1'b0);
	addVector(32'h1234_FB56, `GR_DLR, `GR_IMM, `GR_ZZR, 33'h1_FF56_1234, 8'h10, 8'h00, 1'b0);
	// F1 displacement forms with PC and GBR bases
	addVector(32'h2010_F156, 6'h06, 6'h05, `GR_IMM, 33'h10, 8'h01, 8'h22, 1'b0);
	addVector(32'hA8FF_F170, 6'h07, `GR_PC, `GR_IMM, 33'hFF, 8'h02, 8'h2C, 1'b0);
	addVector(32'h31FF_F119, 6'h09, `GR_GBR, `GR_IMM, 33'h1_FFFF_FFFF, 8'h01, 8'h30, 1'b0);
	addVector(32'h1810_F134, 6'h03, 6'h04, `GR_IMM, 33'h10, 8'h03, 8'h19, 1'b0);
	// F0 indexed forms including the R1 base and index case
	addVector(32'h001C_F041, 6'h04, `GR_TBR, `GR_DLR, 33'h0, 8'h02, 8'h08, 1'b0);
	addVector(32'h00A5_F089, 6'h09, 6'h08, 6'h0A, 33'h0, 8'h01, 8'h11, 1'b0);
	addVector(32'h0834_F050, 6'h05, `GR_PC, 6'h03, 33'h0, 8'h03, 8'h08, 1'b0);
	// BT backward and BSR forward
	addVector(32'hE123_F080, `GR_DLR, `GR_PC, `GR_IMM, 33'h1_FFF8_0123, 8'h4A, 8'h59, 1'b0);
	addVector(32'hD456_F012, `GR_DLR, `GR_PC, `GR_IMM, 33'h1_2456, 8'h0B, 8'h19, 1'b0);
	// bad prefix and unused group
	addVector(32'h1040_7023, `GR_ZZR, `GR_ZZR, `GR_ZZR, 33'h0, 8'h00, 8'h00, 1'b1);
	addVector(32'h0000_F300, `GR_ZZR, `GR_ZZR, `GR_ZZR, 33'h0, 8'h00, 8'h00, 1'b1);
endtask

// applied with ADDSL switched off
task automatic loadDisabledVectors();
	addVector(32'h504C_F023, `GR_ZZR, `GR_ZZR, `GR_ZZR, 33'h0, 8'h00, 8'h00, 1'b1);
	addVector(32'h3045_F223, `GR_ZZR, `GR_ZZR, `GR_ZZR, 33'h0, 8'h00, 8'h00, 1'b1);
	addVector(32'h1040_F023, 6'h02, 6'h03, 6'h04, 33'h3, 8'h04, 8'h00, 1'b0);
endtask

`endif

//--- test/decodeTb.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module decodeTb;

	localparam int RANDOM_ROWS = 8;
	localparam int DISABLED_ROWS = 3;
	localparam int CSR_OPS = 14;

	logic        clock;
	logic        rstN;
	logic        instrValid;
	logic [31:0] instrWord;
	logic        opValid;
	logic [5:0]  regN;
	logic [5:0]  regM;
	logic [5:0]  regO;
	logic [32:0] imm;
	logic [7:0]  uCmd;
	logic [7:0]  uIxt;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	logic [3:0]  wbAdr;
	logic [31:0] wbDatI;
	logic [31:0] wbDatO;
	logic        wbAck;

	int          errors = 0;
	int          totalRows = 0;
	int unsigned seedVal;
	int          expInvCount = 0;
	logic [31:0] expInvWord = 32'h0;

	`include "decodeVectors.svh"

	instrDecoder dut (
		.clock(clock),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrWord(instrWord),
		.opValid(opValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.uCmd(uCmd),
		.uIxt(uIxt),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbDatO(wbDatO),
		.wbAck(wbAck)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, expected);
			$display("CHECKS FAILED");
			$fatal(1, "decode mismatch");
		end
	endtask

	// special when the nibble is R0, R1 or R15
	function automatic logic [5:0] defaultReg(input logic ext, input logic [3:0] nib);
		logic special;
		special = (nib < 4'h2) || (nib == 4'hF);
		return {special, ext, nib};
	endfunction

	task automatic addRandomAlu(input int count);
		logic [3:0] lows [5] = '{4'h0, 4'h1, 4'h5, 4'h6, 4'h7};
		logic [3:0] ext;
		logic [3:0] o;
		logic [3:0] n;
		logic [3:0] m;
		logic [3:0] low;
		int i;
		for (i = 0; i < count; i++) begin
			ext = $urandom;
			o = $urandom;
			n = $urandom;
			m = $urandom;
			low = lows[$urandom % 5];
			addVector({4'h1, ext, o, low, 4'hF, 4'h0, n, m}, defaultReg(ext[2], n),
				defaultReg(ext[1], m), defaultReg(ext[0], o), {28'h0, n[0], m},
				8'h04, {4'h0, low}, 1'b0);
		end
	endtask

	task automatic checkDecode(input decodeVec_t v);
		checkValue("opValid", opValid, 1);
		checkValue("regN", regN, v.regN);
		checkValue("regM", regM, v.regM);
		checkValue("regO", regO, v.regO);
		checkValue("imm", imm, v.imm);
		checkValue("uCmd", uCmd, v.uCmd);
		checkValue("uIxt", uIxt, v.uIxt);
	endtask

	// one word per cycle with each result checked a cycle later
	task automatic streamVectors();
		int i;
		for (i = 0; i <= vecs.size(); i++) begin
			@(negedge clock);
			if (i > 0)
				checkDecode(vecs[i-1]);
			if (i < vecs.size()) begin
				instrValid = 1'b1;
				instrWord = vecs[i].word;
				if (vecs[i].illegal) begin
					expInvCount++;
					expInvWord = vecs[i].word;
				end
			end else begin
				instrValid = 1'b0;
				instrWord = 32'h0;
			end
		end
		@(negedge clock);
		checkValue("opValid", opValid, 0);
	endtask

	task automatic wbAccess(input logic we, input logic [3:0] adr, input logic [31:0] dIn,
		output logic [31:0] dOut);
		int waitCycles;
		waitCycles = 0;
		@(negedge clock);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatI = dIn;
		@(negedge clock);
		while (!wbAck) begin
			if (waitCycles >= 8) begin
				errors++;
				$display("Wishbone slave never acknowledged the request");
				$display("CHECKS FAILED");
				$fatal(1, "bus timeout");
			end
			waitCycles++;
			@(negedge clock);
		end
		dOut = wbDatO;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		@(negedge clock);
		// ack lasts one cycle only
		checkValue("wbAck", wbAck, 0);
	endtask

	task automatic readCheck(input logic [3:0] adr, input logic [31:0] expected,
		input string name);
		logic [31:0] data;
		wbAccess(1'b0, adr, 32'h0, data);
		checkValue(name, data, expected);
	endtask

	task automatic writeReg(input logic [3:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wbAccess(1'b1, adr, data, unused);
	endtask

	initial begin
		#1;
		#((totalRows + CSR_OPS + 50) * 40);
		$display("Simulation ran past its time limit without finishing");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seedVal = $urandom(32'hdb7d);
		rstN = 1'b0;
		instrValid = 1'b0;
		instrWord = 32'h0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 4'h0;
		wbDatI = 32'h0;
		loadMainVectors();
		addRandomAlu(RANDOM_ROWS);
		totalRows = vecs.size() + DISABLED_ROWS;

		repeat (3) begin
			@(negedge clock);
			checkValue("opValid", opValid, 0);
			checkValue("wbAck", wbAck, 0);
		end
		rstN = 1'b1;
		@(negedge clock);
		checkValue("opValid", opValid, 0);
		checkValue("wbAck", wbAck, 0);
		readCheck(`CSR_CTRL, 32'h1, "ctrl");
		readCheck(`CSR_INVCOUNT, 32'h0, "invCount");

		streamVectors();
		readCheck(`CSR_INVCOUNT, expInvCount, "invCount");
		readCheck(`CSR_INVWORD, expInvWord, "invWord");

		// ADDSL off
		writeReg(`CSR_CTRL, 32'h0);
		readCheck(`CSR_CTRL, 32'h0, "ctrl");
		vecs.delete();
		loadDisabledVectors();
		streamVectors();
		readCheck(`CSR_INVCOUNT, expInvCount, "invCount");
		readCheck(`CSR_INVWORD, expInvWord, "invWord");

		writeReg(`CSR_INVCOUNT, 32'hFFFF);
		readCheck(`CSR_INVCOUNT, 32'h0, "invCount");
		// captured word is read-only
		writeReg(`CSR_INVWORD, 32'h1234_5678);
		readCheck(`CSR_INVWORD, expInvWord, "invWord");
		writeReg(`CSR_CTRL, 32'h1);
		readCheck(`CSR_CTRL, 32'h1, "ctrl");

		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
+incdir+test
logic/decodePkg.sv
logic/opClassifier.sv
logic/operandFormer.sv
logic/decodeCsr.sv
logic/instrDecoder.sv
test/decodeTb.sv
